//--- dv/cia_checker.sv
/*
  Assertions on cia_top, attached by bind.
  The mask check holds as long as irq_n is released before the mask is cleared.
*/
`timescale 1ns/1ps

module cia_checker (
  input logic       clk,
  input logic       int_reset,
  input logic       phi2_p,
  input logic       phi2_n,
  input logic [4:0] mask,
  input logic       irq_n,
  input logic [7:0] pra,
  input logic [7:0] ddra,
  input logic [7:0] pa_out
);

  // Strobes come from opposite phi2 edges
  phi2_exclusive: assert property (@(posedge clk) disable iff (int_reset)
    !(phi2_p && phi2_n))
    else $error("phi2_p and phi2_n high in the same cycle");

  irq_needs_mask: assert property (@(posedge clk) disable iff (int_reset)
    (mask == 5'd0 && $past(mask) == 5'd0) |-> irq_n)
    else $error("irq_n low with interrupt mask cleared");

  // A PRA or DDRA write shows at the pins by the next bus access
  pa_follows_ddr: assert property (@(posedge clk) disable iff (int_reset)
    phi2_n |-> (pa_out == (pra | ~ddra)))
    else $error("pa_out differs from port A data merged with DDRA");

endmodule

bind cia_top cia_checker u_checker (
  .clk(clk), .int_reset(int_reset), .phi2_p(phi2_p), .phi2_n(phi2_n),
  .mask(u_int_ctrl.mask), .irq_n(irq_n), .pra(pra), .ddra(ddra), .pa_out(pa_out)
);

//--- dv/cia_tb.sv
/*
  Directed testbench for cia_top.
  phi2 strobes come from a 16-clk phase counter, phi2_p and phi2_n 8 clks apart.
  Port inputs are random but fixed by the seed. Every wait is bounded.
*/
`timescale 1ns/1ps
`include "cia_defines.svh"

module cia_tb;
  import cia_pkg::*;

  localparam int              BUS_TIMEOUT   = 64;
  localparam int              PIN_TIMEOUT   = 400;
  localparam int              POLL_READS    = 40;
  localparam logic [4:0]      TA_FLAG       = 5'(1 << `CIA_IRQ_TA);
  localparam logic [15:0]     CASCADE_START = 16'h0123;
  localparam int              CASCADE_RUNS  = 3;

  logic       clk    = 1'b0;
  logic       phi2_p = 1'b0;
  logic       phi2_n = 1'b0;
  logic [3:0] phase  = 4'd0;
  logic       int_reset;
  logic       cs_n;
  logic       rw;
  logic [3:0] rs;
  logic [7:0] db_in;
  logic [7:0] pa_in;
  logic [7:0] pb_in;
  logic [7:0] db_out;
  logic [7:0] pa_out;
  logic [7:0] pb_out;
  logic       pc_n;
  logic       irq_n;
  int         seed;
  int         error_count;
  int         timeout_count;

  cia_top UUT (
    .clk(clk), .int_reset(int_reset), .phi2_p(phi2_p), .phi2_n(phi2_n),
    .cs_n(cs_n), .rw(rw), .rs(rs), .db_in(db_in), .pa_in(pa_in), .pb_in(pb_in),
    .db_out(db_out), .pa_out(pa_out), .pb_out(pb_out), .pc_n(pc_n), .irq_n(irq_n)
  );

  always #4 clk = ~clk;

  // One phi2 period is 16 clks
  always @(negedge clk) begin
    phase  <= phase + 4'd1;
    phi2_p <= (phase == 4'd15);
    phi2_n <= (phase == 4'd7);
  end

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got %02h expected %02h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_icr(input icr_word_u got, input icr_word_u exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s got irq=%b flags=%05b expected irq=%b flags=%05b",
               $time, what, got.rd.irq, got.rd.flags, exp.rd.irq, exp.rd.flags);
      error_count++;
    end
  endtask

  task automatic expect_pin(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  function automatic icr_word_u icr_expect(input logic irq, input logic [4:0] flags);
    icr_word_u w;
    w          = '0;
    w.rd.irq   = irq;
    w.rd.flags = flags;
    return w;
  endfunction

  // Returns just after the posedge that samples the chosen strobe
  task automatic next_strobe(input bit on_n);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < BUS_TIMEOUT) begin
      @(posedge clk);
      seen = on_n ? phi2_n : phi2_p;
      cycles++;
    end
    if (!seen) begin
      $display("Timeout at %0t: no phi2 strobe within %0d clks", $time, BUS_TIMEOUT);
      timeout_count++;
    end
  endtask

  task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
    @(negedge clk);
    cs_n  = 1'b0;
    rw    = 1'b0;
    rs    = addr;
    db_in = data;
    next_strobe(1'b1);
    @(negedge clk);
    cs_n = 1'b1;
    rw   = 1'b1;
  endtask

  task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
    @(negedge clk);
    cs_n = 1'b0;
    rw   = 1'b1;
    rs   = addr;
    next_strobe(1'b1);
    @(negedge clk);
    data = db_out;
    cs_n = 1'b1;
  endtask

  // is_pc selects pc_n, otherwise irq_n
  task automatic await_pin(input bit is_pc, input logic level, input string what);
    int   cycles;
    logic now;
    cycles = 0;
    now    = is_pc ? pc_n : irq_n;
    while (now !== level && cycles < PIN_TIMEOUT) begin
      @(negedge clk);
      now = is_pc ? pc_n : irq_n;
      cycles++;
    end
    if (now !== level) begin
      $display("Timeout at %0t: %s never reached %b", $time, what, level);
      timeout_count++;
    end
  endtask

  // Reads ICR until a flag shows up; the read that sees it also clears it
  task automatic poll_icr(output icr_word_u word, input bit irq_must_stay_high);
    int         reads;
    logic [7:0] raw;
    reads = 0;
    word  = '0;
    while (word.rd.flags == 5'd0 && reads < POLL_READS) begin
      bus_read(`CIA_REG_ICR, raw);
      word = icr_word_u'(raw);
      if (irq_must_stay_high)
        expect_pin(irq_n, 1'b1, "irq_n with timer source masked off");
      reads++;
    end
    if (word.rd.flags == 5'd0) begin
      $display("Timeout at %0t: no interrupt flag after %0d ICR reads", $time, POLL_READS);
      timeout_count++;
    end
  endtask

  task automatic reset_values;
    @(negedge clk);
    check_byte(db_out, 8'h00, "db_out after reset");
    check_byte(pa_out, 8'hff, "pa_out after reset");
    check_byte(pb_out, 8'hff, "pb_out after reset");
    expect_pin(irq_n, 1'b1, "irq_n after reset");
    expect_pin(pc_n, 1'b1, "pc_n after reset");
  endtask

  task automatic ports_and_handshake;
    logic [7:0] dir;
    logic [7:0] data;
    logic [7:0] rd;
    dir  = 8'($random(seed));
    data = 8'($random(seed));
    bus_write(`CIA_REG_DDRA, dir);
    bus_write(`CIA_REG_PRA, data);
    next_strobe(1'b0);
    @(negedge clk);
    check_byte(pa_out, data | ~dir, "pa_out after DDRA/PRA write");
    bus_read(`CIA_REG_DDRA, rd);
    check_byte(rd, dir, "DDRA readback");
    bus_read(`CIA_REG_PRA, rd);
    check_byte(rd, pa_in, "port A input read");
    expect_pin(pc_n, 1'b1, "pc_n before port B access");
    bus_write(`CIA_REG_PRB, 8'($random(seed)));
    await_pin(1'b1, 1'b0, "pc_n after port B access");
    await_pin(1'b1, 1'b1, "pc_n at end of pulse");
  endtask

  task automatic force_load_readback;
    logic [15:0] val;
    logic [7:0]  rd;
    val = 16'($random(seed));
    // High byte first, so its reload picks up the old low byte
    bus_write(`CIA_REG_TAHI, val[15:8]);
    bus_write(`CIA_REG_TALO, val[7:0]);
    bus_write(`CIA_REG_CRA, 8'h10);
    bus_read(`CIA_REG_TALO, rd);
    check_byte(rd, val[7:0], "Timer A low byte after force load");
    bus_read(`CIA_REG_TAHI, rd);
    check_byte(rd, val[15:8], "Timer A high byte after force load");
    bus_read(`CIA_REG_CRA, rd);
    check_byte(rd, 8'h00, "CRA with force load bit");
  endtask

  task automatic oneshot_interrupt;
    icr_word_u  w;
    logic [7:0] rd;
    w              = '0;
    w.wr.set_clear = 1'b1;
    w.wr.mask      = TA_FLAG;
    bus_write(`CIA_REG_ICR, w);
    bus_write(`CIA_REG_TALO, 8'd3);
    bus_write(`CIA_REG_TAHI, 8'd0);
    // start and one-shot
    bus_write(`CIA_REG_CRA, 8'h09);
    await_pin(1'b0, 1'b0, "irq_n after Timer A one-shot");
    bus_read(`CIA_REG_ICR, rd);
    check_icr(icr_word_u'(rd), icr_expect(1'b1, TA_FLAG), "ICR after underflow");
    bus_read(`CIA_REG_ICR, rd);
    check_icr(icr_word_u'(rd), icr_expect(1'b0, 5'd0), "ICR after clearing read");
    expect_pin(irq_n, 1'b1, "irq_n after ICR read");
    bus_read(`CIA_REG_CRA, rd);
    check_byte(rd, 8'h08, "CRA after one-shot stop");
  endtask

  task automatic masked_underflow;
    icr_word_u w;
    w              = '0;
    w.wr.set_clear = 1'b0;
    w.wr.mask      = TA_FLAG;
    bus_write(`CIA_REG_ICR, w);
    bus_write(`CIA_REG_TALO, 8'd2);
    // One-shot is still selected, so this write starts the timer
    bus_write(`CIA_REG_TAHI, 8'd0);
    poll_icr(w, 1'b1);
    check_icr(w, icr_expect(1'b0, TA_FLAG), "ICR with Timer A masked off");
  endtask

  task automatic timer_b_cascade;
    icr_word_u   w;
    logic [15:0] exp;
    logic [7:0]  rd;
    exp = CASCADE_START - 16'(CASCADE_RUNS);
    bus_write(`CIA_REG_TBLO, CASCADE_START[7:0]);
    bus_write(`CIA_REG_TBHI, CASCADE_START[15:8]);
    // Count Timer A underflows, start
    bus_write(`CIA_REG_CRB, 8'h41);
    for (int run = 0; run < CASCADE_RUNS; run++) begin
      bus_write(`CIA_REG_TAHI, 8'd0);
      poll_icr(w, 1'b1);
      check_icr(w, icr_expect(1'b0, TA_FLAG), "ICR during cascade");
    end
    bus_read(`CIA_REG_TBLO, rd);
    check_byte(rd, exp[7:0], "Timer B low byte after cascade");
    bus_read(`CIA_REG_TBHI, rd);
    check_byte(rd, exp[15:8], "Timer B high byte after cascade");
    bus_write(`CIA_REG_CRB, 8'h00);
  endtask

  task automatic pb6_toggle;
    icr_word_u w;
    logic      lvl;
    lvl = 1'b1;
    // Continuous, toggle, PB6 on, start
    bus_write(`CIA_REG_CRA, 8'h07);
    next_strobe(1'b0);
    @(negedge clk);
    check_byte(pb_out, {1'b1, lvl, 6'h3f}, "pb_out at Timer A start");
    for (int n = 0; n < 3; n++) begin
      poll_icr(w, 1'b1);
      lvl = ~lvl;
      check_byte(pb_out, {1'b1, lvl, 6'h3f}, "pb_out after Timer A underflow");
    end
    bus_write(`CIA_REG_CRA, 8'h00);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    seed          = 59892;
    error_count   = 0;
    timeout_count = 0;
    int_reset     = 1'b1;
    cs_n          = 1'b1;
    rw            = 1'b1;
    rs            = 4'd0;
    db_in         = 8'h00;
    pa_in         = 8'($random(seed));
    pb_in         = 8'($random(seed));
    repeat (10) @(negedge clk);
    int_reset = 1'b0;

    reset_values();
    ports_and_handshake();
    force_load_readback();
    oneshot_interrupt();
    masked_underflow();
    timer_b_cascade();
    pb6_toggle();

    $display("Run complete: %0d value errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+src
src/cia_pkg.sv
src/cia_reg_bus.sv
src/cia_timer.sv
src/cia_int_ctrl.sv
src/cia_port_out.sv
src/cia_top.sv
dv/cia_checker.sv
dv/cia_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the CIA testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cia_tb -f files.f -o cia_sim
./obj_dir/cia_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"

//--- src/cia_defines.svh
/*
  Register map and interrupt source bit positions.
  TOD and serial port addresses are decoded but hold no logic.
  They read as zero and ignore writes.
*/
`ifndef CIA_DEFINES_SVH
`define CIA_DEFINES_SVH

`define CIA_REG_PRA     4'd0
`define CIA_REG_PRB     4'd1
`define CIA_REG_DDRA    4'd2
`define CIA_REG_DDRB    4'd3
`define CIA_REG_TALO    4'd4
`define CIA_REG_TAHI    4'd5
`define CIA_REG_TBLO    4'd6
`define CIA_REG_TBHI    4'd7
`define CIA_REG_TOD_TEN 4'd8
`define CIA_REG_TOD_SEC 4'd9
`define CIA_REG_TOD_MIN 4'd10
`define CIA_REG_TOD_HR  4'd11
`define CIA_REG_SDR     4'd12
`define CIA_REG_ICR     4'd13
`define CIA_REG_CRA     4'd14
`define CIA_REG_CRB     4'd15

// Bit positions in the 5-bit interrupt source field
`define CIA_IRQ_TA 0
`define CIA_IRQ_TB 1

`endif

//--- src/cia_int_ctrl.sv
/*
  Interrupt flags, mask and irq_n. Flags latch on timer underflow.
  A read of ICR clears the flags and releases irq_n on the next phi2_p.
  A flag arriving on that same edge survives the clear.
*/
`timescale 1ns/1ps
`include "cia_defines.svh"

module cia_int_ctrl (
  input  logic               clk,
  input  logic               int_reset,
  input  logic               phi2_p,
  input  logic               ta_underflow,
  input  logic               tb_underflow,
  input  logic               icr_wr,
  input  cia_pkg::icr_word_u icr_wr_word,
  input  logic               icr_rd,
  output cia_pkg::icr_word_u icr_rd_word,
  output logic               irq_n
);

  logic [4:0] src;
  logic [4:0] flags;
  logic [4:0] mask;
  logic       icr_clear;

  always_comb begin
    src                = 5'b00000;
    src[`CIA_IRQ_TA] = ta_underflow;
    src[`CIA_IRQ_TB] = tb_underflow;
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      flags     <= 5'b00000;
      mask      <= 5'b00000;
      icr_clear <= 1'b0;
      irq_n     <= 1'b1;
    end else begin
      if (icr_wr) begin
        if (icr_wr_word.wr.set_clear)
          mask <= mask | icr_wr_word.wr.mask;
        else
          mask <= mask & ~icr_wr_word.wr.mask;
      end
      if (icr_rd)
        icr_clear <= 1'b1;

      // Once low, irq_n waits for the read-clear
      if (irq_n)
        irq_n <= ~|(mask & flags);

      if (phi2_p) begin
        if (icr_clear) begin
          flags     <= src;
          irq_n     <= 1'b1;
          icr_clear <= 1'b0;
        end else begin
          flags <= flags | src;
        end
      end
    end
  end

  always_comb begin
    icr_rd_word          = '0;
    icr_rd_word.rd.irq   = ~irq_n;
    icr_rd_word.rd.flags = flags;
  end

endmodule

//--- src/cia_pkg.sv
/*
  Shared types for the CIA core.
  timer_ctrl_t follows the CRA/CRB bit layout, so a control byte casts
  straight onto it. Only timer interrupt sources exist in the ICR.
*/
package cia_pkg;

  // One bus access, already qualified by phi2 falling edge and chip select
  typedef struct packed {
    logic       rd;
    logic       wr;
    logic [3:0] addr;
    logic [7:0] wdata;
  } bus_req_t;

  // Bit 7 down to bit 0 of the control register
  typedef struct packed {
    logic       spare;
    logic [1:0] in_mode;
    logic       force_load;
    logic       oneshot;
    logic       toggle;
    logic       pb_on;
    logic       start;
  } timer_ctrl_t;

  typedef struct packed {
    logic [15:0] value;
    logic        underflow;
    logic        pb_level;
    logic        running;
  } timer_stat_t;

  // ICR byte as written by the host
  typedef struct packed {
    logic       set_clear;
    logic [1:0] unused;
    logic [4:0] mask;
  } icr_wr_t;

  // ICR byte as returned to the host
  typedef struct packed {
    logic       irq;
    logic [1:0] unused;
    logic [4:0] flags;
  } icr_rd_t;

  typedef union packed {
    icr_wr_t wr;
    icr_rd_t rd;
  } icr_word_u;

endpackage

//--- src/cia_port_out.sv
/*
  Port A/B output drivers, updated on phi2_p.
  Undriven bits (DDR clear) read as one at the pins.
  PB6/PB7 follow the timer output while its pb_on bit is set.
*/
`timescale 1ns/1ps

module cia_port_out (
  input  logic                 clk,
  input  logic                 int_reset,
  input  logic                 phi2_p,
  input  logic [7:0]           pra,
  input  logic [7:0]           prb,
  input  logic [7:0]           ddra,
  input  logic [7:0]           ddrb,
  input  cia_pkg::timer_stat_t ta_stat,
  input  cia_pkg::timer_stat_t tb_stat,
  input  logic                 ta_pb_on,
  input  logic                 tb_pb_on,
  input  logic                 prb_access,
  output logic [7:0]           pa_out,
  output logic [7:0]           pb_out,
  output logic                 pc_n
);

  logic [7:0] pb_merged;
  logic       pc_pend_n;

  always_comb begin
    pb_merged = prb | ~ddrb;
    if (ta_pb_on)
      pb_merged[6] = ta_stat.pb_level;
    if (tb_pb_on)
      pb_merged[7] = tb_stat.pb_level;
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pa_out <= 8'hff;
      pb_out <= 8'hff;
    end else if (phi2_p) begin
      pa_out <= pra | ~ddra;
      pb_out <= pb_merged;
    end
  end

  // Handshake pulse, low for one phi2 period after a PRB access
  always_ff @(posedge clk) begin
    if (int_reset) begin
      pc_pend_n <= 1'b1;
      pc_n      <= 1'b1;
    end else begin
      if (prb_access)
        pc_pend_n <= 1'b0;
      if (phi2_p) begin
        pc_n      <= pc_pend_n;
        pc_pend_n <= 1'b1;
      end
    end
  end

endmodule

//--- src/cia_reg_bus.sv
/*
  Host register interface. Accesses are sampled on phi2_n with cs_n low.
  db_out is registered and holds the last read value.
  A high latch byte write reloads a stopped or one-shot timer and
  starts it in one-shot mode. Force load reads back as zero.
*/
`timescale 1ns/1ps
`include "cia_defines.svh"

module cia_reg_bus (
  input  logic                   clk,
  input  logic                   int_reset,
  input  logic                   phi2_n,
  input  logic                   cs_n,
  input  logic                   rw,
  input  logic [3:0]             rs,
  input  logic [7:0]             db_in,
  input  logic [7:0]             pa_in,
  input  logic [7:0]             pb_in,
  input  cia_pkg::timer_stat_t   ta_stat,
  input  cia_pkg::timer_stat_t   tb_stat,
  input  cia_pkg::icr_word_u     icr_rd_word,
  output cia_pkg::timer_ctrl_t   ta_ctrl,
  output cia_pkg::timer_ctrl_t   tb_ctrl,
  output logic [15:0]            ta_latch,
  output logic [15:0]            tb_latch,
  output logic                   ta_reload,
  output logic                   tb_reload,
  output cia_pkg::icr_word_u     icr_wr_word,
  output logic                   icr_wr,
  output logic                   icr_rd,
  output logic [7:0]             pra,
  output logic [7:0]             prb,
  output logic [7:0]             ddra,
  output logic [7:0]             ddrb,
  output logic                   prb_access,
  output logic [7:0]             db_out
);
  import cia_pkg::*;

  // Per-timer register addresses, index 0 is Timer A
  localparam logic [3:0] LO_ADDR [2] = '{`CIA_REG_TALO, `CIA_REG_TBLO};
  localparam logic [3:0] HI_ADDR [2] = '{`CIA_REG_TAHI, `CIA_REG_TBHI};
  localparam logic [3:0] CR_ADDR [2] = '{`CIA_REG_CRA, `CIA_REG_CRB};

  bus_req_t    req;
  timer_ctrl_t cr [2];
  timer_ctrl_t cra_rd;
  timer_ctrl_t crb_rd;
  logic [15:0] tlatch [2];
  logic [1:0]  reload;
  logic [1:0]  run_q;
  logic [1:0]  run_now;

  always_comb begin
    req.rd    = phi2_n & ~cs_n & rw;
    req.wr    = phi2_n & ~cs_n & ~rw;
    req.addr  = rs;
    req.wdata = db_in;
  end

  assign run_now = {tb_stat.running, ta_stat.running};

  always_ff @(posedge clk) begin
    if (int_reset) begin
      pra    <= 8'h00;
      prb    <= 8'h00;
      ddra   <= 8'h00;
      ddrb   <= 8'h00;
      reload <= 2'b00;
      run_q  <= 2'b00;
      for (int i = 0; i < 2; i++) begin
        cr[i]     <= '0;
        tlatch[i] <= 16'hffff;
      end
    end else begin
      run_q  <= run_now;
      reload <= 2'b00;
      for (int i = 0; i < 2; i++) begin
        // Force load is a single-clk request to the timer
        cr[i].force_load <= 1'b0;
        // One-shot auto-stop reported back by the timer
        if (run_q[i] && !run_now[i])
          cr[i].start <= 1'b0;
        if (req.wr) begin
          if (req.addr == LO_ADDR[i])
            tlatch[i][7:0] <= req.wdata;
          if (req.addr == HI_ADDR[i]) begin
            tlatch[i][15:8] <= req.wdata;
            if (!cr[i].start || cr[i].oneshot) begin
              reload[i] <= 1'b1;
              if (cr[i].oneshot)
                cr[i].start <= 1'b1;
            end
          end
          if (req.addr == CR_ADDR[i])
            cr[i] <= timer_ctrl_t'(req.wdata);
        end
      end
      if (req.wr) begin
        case (req.addr)
          `CIA_REG_PRA:  pra  <= req.wdata;
          `CIA_REG_PRB:  prb  <= req.wdata;
          `CIA_REG_DDRA: ddra <= req.wdata;
          `CIA_REG_DDRB: ddrb <= req.wdata;
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    cra_rd            = cr[0];
    cra_rd.force_load = 1'b0;
    crb_rd            = cr[1];
    crb_rd.force_load = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (int_reset) begin
      db_out <= 8'h00;
    end else if (req.rd) begin
      case (req.addr)
        `CIA_REG_PRA:  db_out <= pa_in;
        `CIA_REG_PRB:  db_out <= pb_in;
        `CIA_REG_DDRA: db_out <= ddra;
        `CIA_REG_DDRB: db_out <= ddrb;
        `CIA_REG_TALO: db_out <= ta_stat.value[7:0];
        `CIA_REG_TAHI: db_out <= ta_stat.value[15:8];
        `CIA_REG_TBLO: db_out <= tb_stat.value[7:0];
        `CIA_REG_TBHI: db_out <= tb_stat.value[15:8];
        `CIA_REG_TOD_TEN, `CIA_REG_TOD_SEC, `CIA_REG_TOD_MIN, `CIA_REG_TOD_HR,
        `CIA_REG_SDR:  db_out <= 8'h00;
        `CIA_REG_ICR:  db_out <= icr_rd_word;
        `CIA_REG_CRA:  db_out <= cra_rd;
        `CIA_REG_CRB:  db_out <= crb_rd;
      endcase
    end
  end

  assign icr_wr      = req.wr & (req.addr == `CIA_REG_ICR);
  assign icr_rd      = req.rd & (req.addr == `CIA_REG_ICR);
  assign icr_wr_word = icr_word_u'(req.wdata);
  assign prb_access  = (req.rd | req.wr) & (req.addr == `CIA_REG_PRB);

  assign ta_ctrl   = cr[0];
  assign tb_ctrl   = cr[1];
  assign ta_latch  = tlatch[0];
  assign tb_latch  = tlatch[1];
  assign ta_reload = reload[0];
  assign tb_reload = reload[1];

endmodule

//--- src/cia_timer.sv
/*
  16-bit interval timer. Counts on phi2_p when count_src is high.
  The first decrement comes on the second phi2_p after start.
  A value N underflows once per N+1 counted edges.
  The underflow pulse is combinational in the phi2_p cycle.
*/
`timescale 1ns/1ps

module cia_timer (
  input  logic                 clk,
  input  logic                 int_reset,
  input  logic                 phi2_p,
  input  cia_pkg::timer_ctrl_t ctrl,
  input  logic [15:0]          latch,
  input  logic                 reload,
  input  logic                 count_src,
  output cia_pkg::timer_stat_t stat
);

  logic [15:0] value;
  logic [15:0] next_value;
  logic        running;
  logic        start_q;
  logic        dec_q;
  logic        load_pend;
  logic        toggle_ff;
  logic        count_now;
  logic        underflow;

  // Stage one qualifies the edge, stage two applies the decrement
  assign count_now  = count_src & running;
  assign next_value = dec_q ? value - 16'd1 : value;
  assign underflow  = phi2_p & count_now & (next_value == 16'd0);

  always_ff @(posedge clk) begin
    if (int_reset) begin
      value     <= 16'h0000;
      running   <= 1'b0;
      start_q   <= 1'b0;
      dec_q     <= 1'b0;
      load_pend <= 1'b0;
      toggle_ff <= 1'b0;
    end else begin
      start_q <= ctrl.start;
      if (!ctrl.start) begin
        running <= 1'b0;
      end else if (!start_q) begin
        running   <= 1'b1;
        toggle_ff <= 1'b1;
      end

      if (ctrl.force_load)
        load_pend <= 1'b1;

      if (phi2_p) begin
        value <= next_value;
        dec_q <= count_now;
        if (underflow) begin
          value     <= latch;
          dec_q     <= 1'b0;
          toggle_ff <= ~toggle_ff;
          if (ctrl.oneshot)
            running <= 1'b0;
        end
        if (load_pend) begin
          value     <= latch;
          dec_q     <= 1'b0;
          load_pend <= 1'b0;
        end
      end

      // Host wrote the high latch byte while stopped or in one-shot
      if (reload) begin
        value <= latch;
        dec_q <= 1'b0;
      end
    end
  end

  always_comb begin
    stat.value     = value;
    stat.underflow = underflow;
    stat.pb_level  = ctrl.toggle ? (toggle_ff ^ underflow) : underflow;
    stat.running   = running;
  end

endmodule

//--- src/cia_top.sv
/*
  8520-style CIA without TOD, serial port, FLAG or CNT counting.
  phi2_p and phi2_n are one-clk strobes in the clk domain.
  Timer B counts Timer A underflows when CRB in_mode bit 1 is set.
*/
`timescale 1ns/1ps

module cia_top (
  input  logic       clk,
  input  logic       int_reset,
  input  logic       phi2_p,
  input  logic       phi2_n,
  input  logic       cs_n,
  input  logic       rw,
  input  logic [3:0] rs,
  input  logic [7:0] db_in,
  input  logic [7:0] pa_in,
  input  logic [7:0] pb_in,
  output logic [7:0] db_out,
  output logic [7:0] pa_out,
  output logic [7:0] pb_out,
  output logic       pc_n,
  output logic       irq_n
);
  import cia_pkg::*;

  timer_ctrl_t ta_ctrl;
  timer_ctrl_t tb_ctrl;
  timer_stat_t ta_stat;
  timer_stat_t tb_stat;
  icr_word_u   icr_wr_word;
  icr_word_u   icr_rd_word;
  logic [15:0] ta_latch;
  logic [15:0] tb_latch;
  logic        ta_reload;
  logic        tb_reload;
  logic        icr_wr;
  logic        icr_rd;
  logic [7:0]  pra;
  logic [7:0]  prb;
  logic [7:0]  ddra;
  logic [7:0]  ddrb;
  logic        prb_access;
  logic        tb_count_src;

  assign tb_count_src = tb_ctrl.in_mode[1] ? ta_stat.underflow : 1'b1;

  cia_reg_bus u_reg_bus (
    .clk(clk), .int_reset(int_reset), .phi2_n(phi2_n), .cs_n(cs_n), .rw(rw),
    .rs(rs), .db_in(db_in), .pa_in(pa_in), .pb_in(pb_in),
    .ta_stat(ta_stat), .tb_stat(tb_stat), .icr_rd_word(icr_rd_word),
    .ta_ctrl(ta_ctrl), .tb_ctrl(tb_ctrl), .ta_latch(ta_latch), .tb_latch(tb_latch),
    .ta_reload(ta_reload), .tb_reload(tb_reload),
    .icr_wr_word(icr_wr_word), .icr_wr(icr_wr), .icr_rd(icr_rd),
    .pra(pra), .prb(prb), .ddra(ddra), .ddrb(ddrb),
    .prb_access(prb_access), .db_out(db_out)
  );

  cia_timer u_timer_a (
    .clk(clk), .int_reset(int_reset), .phi2_p(phi2_p), .ctrl(ta_ctrl),
    .latch(ta_latch), .reload(ta_reload), .count_src(1'b1), .stat(ta_stat)
  );

  cia_timer u_timer_b (
    .clk(clk), .int_reset(int_reset), .phi2_p(phi2_p), .ctrl(tb_ctrl),
    .latch(tb_latch), .reload(tb_reload), .count_src(tb_count_src), .stat(tb_stat)
  );

  cia_int_ctrl u_int_ctrl (
    .clk(clk), .int_reset(int_reset), .phi2_p(phi2_p),
    .ta_underflow(ta_stat.underflow), .tb_underflow(tb_stat.underflow),
    .icr_wr(icr_wr), .icr_wr_word(icr_wr_word), .icr_rd(icr_rd),
    .icr_rd_word(icr_rd_word), .irq_n(irq_n)
  );

  cia_port_out u_port_out (
    .clk(clk), .int_reset(int_reset), .phi2_p(phi2_p),
    .pra(pra), .prb(prb), .ddra(ddra), .ddrb(ddrb),
    .ta_stat(ta_stat), .tb_stat(tb_stat),
    .ta_pb_on(ta_ctrl.pb_on), .tb_pb_on(tb_ctrl.pb_on),
    .prb_access(prb_access), .pa_out(pa_out), .pb_out(pb_out), .pc_n(pc_n)
  );

endmodule
